//--- hdl/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

// memLatency of 1 or more
module controlSequencer
#(
	parameter int memLatency = mipsControlPkg::defaultMemLatency
)
(
	input wire logic clk,
	input wire logic reset,
	input mipsControlPkg::instrClassT instrClass,
	output mipsControlPkg::ctrlStateT state
);

	import mipsControlPkg::*;

	localparam int cntWidth = (memLatency > 1) ? $clog2(memLatency) : 1;
	localparam logic [cntWidth-1:0] lastCount = cntWidth'(memLatency - 1);

	ctrlStateT nextState;
	logic [cntWidth-1:0] waitCount;
	logic inWait;
	logic waitDone;

	assign inWait = (state == stMemWait) || (state == stLwWait) || (state == stSwWait);
	assign waitDone = (waitCount == lastCount); // last cycle of a wait state

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= stReset;
			waitCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (inWait && !waitDone)
				waitCount <= waitCount + 1'b1;
			else
				waitCount <= '0; // zero again before the next wait state
		end
	end

	always_comb
	begin
		case (state)
			stReset: nextState = stMemRead;
			stMemRead: nextState = stMemWait;
			stMemWait: nextState = waitDone ? stIrWrite : stMemWait;
			stIrWrite: nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					clsAdd: nextState = stAdd;
					clsAnd: nextState = stAnd;
					clsSub: nextState = stSub;
					clsXor: nextState = stXor;
					clsNop: nextState = stNop;
					clsJr: nextState = stJr;
					clsBreak: nextState = stBreak;
					clsBeq: nextState = stBeq;
					clsBne: nextState = stBne;
					clsLw: nextState = stLw;
					clsSw: nextState = stSw;
					clsLui: nextState = stLui;
					clsJ: nextState = stJ;
					clsAddiu: nextState = stAddiu;
					default: nextState = stMemRead; // unknown, fetch the next one
				endcase
			end
			stAdd, stAnd, stSub, stXor: nextState = stWriteRegAlu;
			stWriteRegAlu: nextState = stMemRead;
			stBreak: nextState = stBreak; // only reset leaves
			stNop: nextState = stMemRead;
			stBeq, stBne: nextState = stMemRead;
			stLw: nextState = stLwAddr;
			stLwAddr: nextState = stLwWait;
			stLwWait: nextState = waitDone ? stLwMdr : stLwWait;
			stLwMdr: nextState = stLwWrite;
			stLwWrite: nextState = stMemRead;
			stSw: nextState = stSwWrite;
			stSwWrite: nextState = stSwWait;
			stSwWait: nextState = waitDone ? stMemRead : stSwWait;
			stLui, stJ, stJr: nextState = stMemRead;
			stAddiu: nextState = stWriteRegAluImm;
			stWriteRegAluImm: nextState = stMemRead;
			default: nextState = stMemRead;
		endcase
	end

endmodule : controlSequencer

`default_nettype wire

//--- hdl/controlSignalGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlSignalGen
(
	input mipsControlPkg::ctrlStateT state,
	output logic memWrite,
	output logic mdrWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output mipsControlPkg::pcSourceT pcSource,
	output logic branchOnEqual,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluSrcA,
	output mipsControlPkg::aluSrcBT aluSrcB,
	output mipsControlPkg::aluOpT aluOp,
	output logic aluOutWrite,
	output logic regDst,
	output mipsControlPkg::memToRegT memToReg,
	output logic iOrD
);

	import mipsControlPkg::*;

	always_comb
	begin
		// default set, every state overrides what differs
		memWrite = 1'b0;
		mdrWrite = 1'b0;
		pcWrite = 1'b0;
		pcWriteCond = 1'b0;
		pcSource = pcAluResult;
		branchOnEqual = 1'b0;
		irWrite = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		regWrite = 1'b0;
		aluSrcA = 1'b0; // pc
		aluSrcB = srcBReg;
		aluOp = aluAdd;
		aluOutWrite = 1'b0;
		regDst = 1'b0;
		memToReg = wbAlu;
		iOrD = 1'b1; // memory addressed by aluOut

		case (state)
			stMemRead, stMemWait:
			begin
				iOrD = 1'b0; // address from pc
				aluSrcB = srcBFour; // pc + 4
				aWrite = 1'b1;
				bWrite = 1'b1;
			end
			stIrWrite:
			begin
				iOrD = 1'b0;
				irWrite = 1'b1;
				pcWrite = 1'b1;
				pcSource = pcAluResult;
				aluSrcB = srcBFour; // keep pc + 4 on the ALU output
				aWrite = 1'b1;
				bWrite = 1'b1;
			end
			stDecode:
			begin
				aluOutWrite = 1'b1; // branch target into aluOut
				aluSrcB = srcBImmShift;
				aWrite = 1'b1;
				bWrite = 1'b1;
			end
			stAdd, stAnd, stSub, stXor:
			begin
				aluSrcA = 1'b1;
				aluOutWrite = 1'b1;
				case (state)
					stAnd: aluOp = aluAnd;
					stSub: aluOp = aluSub;
					stXor: aluOp = aluXor;
					default: aluOp = aluAdd;
				endcase
			end
			stWriteRegAlu:
			begin
				regWrite = 1'b1;
				regDst = 1'b1; // rd
				memToReg = wbAlu;
			end
			stBeq, stBne:
			begin
				pcWriteCond = 1'b1;
				branchOnEqual = (state == stBeq);
				aluSrcA = 1'b1; // compare A with B
				aluOp = aluSub;
				pcSource = pcBranchTarget;
			end
			stLw, stSw, stAddiu:
			begin
				aluSrcA = 1'b1; // base plus offset
				aluSrcB = srcBImm;
				aluOutWrite = 1'b1;
				aWrite = (state != stAddiu); // address states
				bWrite = (state != stAddiu);
			end
			stLwMdr: mdrWrite = 1'b1;
			stLwWrite:
			begin
				regWrite = 1'b1;
				memToReg = wbMem;
			end
			stSwWrite, stSwWait: memWrite = 1'b1;
			stLui:
			begin
				regWrite = 1'b1;
				memToReg = wbLui;
			end
			stJ:
			begin
				pcWrite = 1'b1;
				pcSource = pcJumpTarget;
			end
			stJr:
			begin
				pcWrite = 1'b1;
				pcSource = pcRegister;
			end
			stWriteRegAluImm:
			begin
				regWrite = 1'b1;
				regDst = 1'b0; // rt
				memToReg = wbAlu;
			end
			stBreak, stNop:
			begin
				iOrD = 1'b0;
				aluOp = aluPass; // everything idle
			end
			default: ; // stReset, stLwAddr, stLwWait keep the default set
		endcase
	end

endmodule : controlSignalGen

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
(
	input mipsControlPkg::opcodeT opcode,
	input mipsControlPkg::functT funct,
	output mipsControlPkg::instrClassT instrClass
);

	import mipsControlPkg::*;

	instrClassT rTypeClass; // verdict from funct alone

	always_comb
	begin
		case (funct)
			fnAdd: rTypeClass = clsAdd;
			fnAnd: rTypeClass = clsAnd;
			fnSub: rTypeClass = clsSub;
			fnXor: rTypeClass = clsXor;
			fnNop: rTypeClass = clsNop;
			fnJr: rTypeClass = clsJr;
			fnBreak: rTypeClass = clsBreak;
			default: rTypeClass = clsUnknown; // shifts and the rest
		endcase
	end

	always_comb
	begin
		case (opcode)
			rType: instrClass = rTypeClass;
			beq: instrClass = clsBeq;
			bne: instrClass = clsBne;
			lw: instrClass = clsLw;
			sw: instrClass = clsSw;
			lui: instrClass = clsLui;
			j: instrClass = clsJ;
			addiu: instrClass = clsAddiu;
			default: instrClass = clsUnknown;
		endcase
	end

endmodule : instrDecoder

`default_nettype wire

//--- hdl/mipsControlPkg.sv
`default_nettype none

package mipsControlPkg;

	localparam int opFieldWidth = 6; // instr[31:26]
	localparam int functFieldWidth = 6; // instr[5:0]

	localparam int defaultMemLatency = 1; // wait cycles per memory access

	typedef enum logic [opFieldWidth-1:0] {
		rType = 6'h00,
		j = 6'h02,
		beq = 6'h04,
		bne = 6'h05,
		addiu = 6'h09,
		lui = 6'h0F,
		lw = 6'h23,
		sw = 6'h2B
	} opcodeT;

	typedef enum logic [functFieldWidth-1:0] {
		fnNop = 6'h00, // sll $0,$0,0
		fnJr = 6'h08,
		fnBreak = 6'h0D,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnXor = 6'h26
	} functT;

	typedef enum logic [3:0] {
		clsAdd,
		clsAnd,
		clsSub,
		clsXor,
		clsNop,
		clsJr,
		clsBreak,
		clsBeq,
		clsBne,
		clsLw,
		clsSw,
		clsLui,
		clsJ,
		clsAddiu,
		clsUnknown
	} instrClassT;

	typedef enum logic [4:0] {
		stReset, stMemRead, stMemWait, stIrWrite, stDecode, // fetch and decode
		stAdd, stAnd, stSub, stXor, stWriteRegAlu, stBreak, stNop,
		stBeq, stBne,
		stLw, stLwAddr, stLwWait, stLwMdr, stLwWrite,
		stSw, stSwWrite, stSwWait,
		stLui, stJ, stJr, stAddiu, stWriteRegAluImm
	} ctrlStateT;

	// encodings match the datapath ALU
	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluXor = 3'd6
	} aluOpT;

	typedef enum logic [1:0] {
		srcBReg, // register B
		srcBFour, // constant 4 for pc increment
		srcBImm, // sign extended immediate
		srcBImmShift // immediate shifted left 2
	} aluSrcBT;

	typedef enum logic [1:0] {
		pcAluResult,
		pcBranchTarget, // aluOut from decode
		pcJumpTarget,
		pcRegister // jr
	} pcSourceT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLui
	} memToRegT;

endpackage : mipsControlPkg

`default_nettype wire

//--- hdl/mipsControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControlUnit
#(
	parameter int memLatency = mipsControlPkg::defaultMemLatency
)
(
	input wire logic clk,
	input wire logic reset,
	input mipsControlPkg::opcodeT opcode,
	input mipsControlPkg::functT funct,
	output mipsControlPkg::ctrlStateT stateOut,
	output logic memWrite,
	output logic mdrWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output mipsControlPkg::pcSourceT pcSource,
	output logic branchOnEqual,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluSrcA,
	output mipsControlPkg::aluSrcBT aluSrcB,
	output mipsControlPkg::aluOpT aluOp,
	output logic aluOutWrite,
	output logic regDst,
	output mipsControlPkg::memToRegT memToReg,
	output logic iOrD
);

	import mipsControlPkg::*;

	instrClassT instrClass; // decoder verdict, used in stDecode

	instrDecoder instrDecoder_inst (
		.opcode(opcode),
		.funct(funct),
		.instrClass(instrClass)
	);

	controlSequencer #(
		.memLatency(memLatency)
	) controlSequencer_inst (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.state(stateOut)
	);

	controlSignalGen controlSignalGen_inst (
		.state(stateOut),
		.memWrite(memWrite),
		.mdrWrite(mdrWrite),
		.pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond),
		.pcSource(pcSource),
		.branchOnEqual(branchOnEqual),
		.irWrite(irWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.aluOutWrite(aluOutWrite),
		.regDst(regDst),
		.memToReg(memToReg),
		.iOrD(iOrD)
	);

endmodule : mipsControlUnit

`default_nettype wire

//--- mipsControlUnit.f
hdl/mipsControlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlSignalGen.sv
hdl/mipsControlUnit.sv
test/mipsControlUnit_properties.sv
test/mipsControlUnitTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --timescale 1ns/1ps -f mipsControlUnit.f \
	--top-module mipsControlUnitTb -o mipsControlUnitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mipsControlUnitSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$logFile"; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi
exit 0

//--- test/mipsControlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControlUnitTb;

	import mipsControlPkg::*;

	localparam int latency = 2; // memory wait cycles
	localparam int timeoutCycles = 2000; // well above the whole run

	logic clk;
	logic reset;
	opcodeT opcode;
	functT funct;
	ctrlStateT stateOut;
	logic memWrite;
	logic mdrWrite;
	logic pcWrite;
	logic pcWriteCond;
	logic branchOnEqual;
	logic irWrite;
	logic aWrite;
	logic bWrite;
	logic regWrite;
	logic aluSrcA;
	logic aluOutWrite;
	logic regDst;
	logic iOrD;
	pcSourceT pcSource;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	memToRegT memToReg;
	integer seed;
	int cycleCount = 0;

	mipsControlUnit #(.memLatency(latency)) mipsControlUnit_inst (
		.clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .stateOut(stateOut),
		.memWrite(memWrite), .mdrWrite(mdrWrite), .pcWrite(pcWrite),
		.pcWriteCond(pcWriteCond), .pcSource(pcSource), .branchOnEqual(branchOnEqual),
		.irWrite(irWrite), .aWrite(aWrite), .bWrite(bWrite), .regWrite(regWrite),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp), .aluOutWrite(aluOutWrite),
		.regDst(regDst), .memToReg(memToReg), .iOrD(iOrD)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at the first failure");
	endtask

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
			reportFailure($sformatf("run did not finish within %0d cycles", timeoutCycles));
	end

	task automatic checkState(input string testName, input ctrlStateT expected,
		input ctrlStateT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: state expected %s actual %s",
				testName, expected.name(), actual.name()));
	endtask

	task automatic checkAluOp(input string testName, input aluOpT expected, input aluOpT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: aluOp expected %s actual %s",
				testName, expected.name(), actual.name()));
	endtask

	task automatic checkAluSrcB(input string testName, input aluSrcBT expected,
		input aluSrcBT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: aluSrcB expected %s actual %s",
				testName, expected.name(), actual.name()));
	endtask

	task automatic checkPcSource(input string testName, input pcSourceT expected,
		input pcSourceT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: pcSource expected %s actual %s",
				testName, expected.name(), actual.name()));
	endtask

	task automatic checkMemToReg(input string testName, input memToRegT expected,
		input memToRegT actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: memToReg expected %s actual %s",
				testName, expected.name(), actual.name()));
	endtask

	task automatic checkBit(input string testName, input string sigName, input logic expected,
		input logic actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: %s expected %b actual %b",
				testName, sigName, expected, actual));
	endtask

	task automatic checkWritesOff(input string testName);
		checkBit(testName, "regWrite", 1'b0, regWrite);
		checkBit(testName, "memWrite", 1'b0, memWrite);
		checkBit(testName, "pcWrite", 1'b0, pcWrite);
		checkBit(testName, "pcWriteCond", 1'b0, pcWriteCond);
		checkBit(testName, "mdrWrite", 1'b0, mdrWrite);
		checkBit(testName, "irWrite", 1'b0, irWrite);
	endtask

	// one clock of random instruction bits up to the falling edge
	task automatic idleCycle();
		logic [31:0] r;
		@(posedge clk);
		r = $random(seed);
		opcode <= opcodeT'(r[5:0]);
		funct <= functT'(r[11:6]);
		@(negedge clk);
	endtask

	task automatic decodeCycle(input opcodeT op, input functT fn);
		@(posedge clk);
		opcode <= op; // held through stDecode
		funct <= fn;
		@(negedge clk);
	endtask

	task automatic applyReset(input string testName);
		@(posedge clk);
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkState(testName, stReset, stateOut);
		checkWritesOff(testName);
		idleCycle();
		checkState(testName, stMemRead, stateOut);
	endtask

	// runs from stMemRead until the instruction sits in stDecode
	task automatic fetchAndDecode(input string testName, input opcodeT op, input functT fn);
		checkState(testName, stMemRead, stateOut);
		checkBit(testName, "iOrD", 1'b0, iOrD);
		checkAluSrcB(testName, srcBFour, aluSrcB);
		checkBit(testName, "aWrite", 1'b1, aWrite);
		checkBit(testName, "bWrite", 1'b1, bWrite);
		for (int i = 0; i < latency; i++)
		begin
			idleCycle();
			checkState(testName, stMemWait, stateOut);
			checkBit(testName, "iOrD", 1'b0, iOrD);
		end
		idleCycle();
		checkState(testName, stIrWrite, stateOut);
		checkBit(testName, "irWrite", 1'b1, irWrite);
		checkBit(testName, "pcWrite", 1'b1, pcWrite);
		checkPcSource(testName, pcAluResult, pcSource);
		decodeCycle(op, fn);
		checkState(testName, stDecode, stateOut);
		checkBit(testName, "aluOutWrite", 1'b1, aluOutWrite);
		checkBit(testName, "irWrite", 1'b0, irWrite);
		checkAluSrcB(testName, srcBImmShift, aluSrcB);
		checkBit(testName, "aWrite", 1'b1, aWrite);
		checkBit(testName, "bWrite", 1'b1, bWrite);
	endtask

	task automatic expectFetchNext(input string testName);
		idleCycle();
		checkState(testName, stMemRead, stateOut);
		checkWritesOff(testName);
	endtask

	task automatic testResetAndFetch();
		applyReset("resetAndFetch");
		fetchAndDecode("resetAndFetch", rType, fnNop);
		idleCycle();
		checkState("resetAndFetch", stNop, stateOut);
		expectFetchNext("resetAndFetch");
	endtask

	task automatic testRTypeAlu();
		functT fns [4];
		ctrlStateT states [4];
		aluOpT ops [4];
		fns = '{fnAdd, fnAnd, fnSub, fnXor};
		states = '{stAdd, stAnd, stSub, stXor};
		ops = '{aluAdd, aluAnd, aluSub, aluXor};
		for (int i = 0; i < 4; i++)
		begin
			fetchAndDecode("rTypeAlu", rType, fns[i]);
			idleCycle();
			checkState("rTypeAlu", states[i], stateOut);
			checkAluOp("rTypeAlu", ops[i], aluOp);
			checkBit("rTypeAlu", "aluSrcA", 1'b1, aluSrcA);
			idleCycle();
			checkState("rTypeAlu", stWriteRegAlu, stateOut);
			checkBit("rTypeAlu", "regWrite", 1'b1, regWrite);
			checkBit("rTypeAlu", "regDst", 1'b1, regDst);
			checkMemToReg("rTypeAlu", wbAlu, memToReg);
			expectFetchNext("rTypeAlu");
		end
	endtask

	task automatic testLoadStore();
		fetchAndDecode("loadStore", lw, fnNop);
		idleCycle();
		checkState("loadStore", stLw, stateOut);
		checkAluSrcB("loadStore", srcBImm, aluSrcB);
		checkBit("loadStore", "aluOutWrite", 1'b1, aluOutWrite);
		checkBit("loadStore", "aWrite", 1'b1, aWrite);
		checkBit("loadStore", "bWrite", 1'b1, bWrite);
		idleCycle();
		checkState("loadStore", stLwAddr, stateOut);
		checkBit("loadStore", "iOrD", 1'b1, iOrD);
		repeat (latency)
		begin
			idleCycle();
			checkState("loadStore", stLwWait, stateOut);
			checkBit("loadStore", "mdrWrite", 1'b0, mdrWrite);
		end
		idleCycle();
		checkState("loadStore", stLwMdr, stateOut);
		checkBit("loadStore", "mdrWrite", 1'b1, mdrWrite);
		idleCycle();
		checkState("loadStore", stLwWrite, stateOut);
		checkBit("loadStore", "regWrite", 1'b1, regWrite);
		checkMemToReg("loadStore", wbMem, memToReg);
		expectFetchNext("loadStore");
		fetchAndDecode("loadStore", sw, fnNop);
		idleCycle();
		checkState("loadStore", stSw, stateOut);
		checkBit("loadStore", "memWrite", 1'b0, memWrite);
		checkAluSrcB("loadStore", srcBImm, aluSrcB);
		idleCycle();
		checkState("loadStore", stSwWrite, stateOut);
		checkBit("loadStore", "memWrite", 1'b1, memWrite);
		checkBit("loadStore", "iOrD", 1'b1, iOrD);
		repeat (latency)
		begin
			idleCycle();
			checkState("loadStore", stSwWait, stateOut);
			checkBit("loadStore", "memWrite", 1'b1, memWrite);
		end
		expectFetchNext("loadStore"); // memWrite back low
	endtask

	task automatic runBranch(input opcodeT op, input ctrlStateT expState, input logic expEq);
		fetchAndDecode("branchesAndJumps", op, fnNop);
		idleCycle();
		checkState("branchesAndJumps", expState, stateOut);
		checkBit("branchesAndJumps", "pcWriteCond", 1'b1, pcWriteCond);
		checkBit("branchesAndJumps", "branchOnEqual", expEq, branchOnEqual);
		checkBit("branchesAndJumps", "pcWrite", 1'b0, pcWrite);
		checkPcSource("branchesAndJumps", pcBranchTarget, pcSource);
		checkAluOp("branchesAndJumps", aluSub, aluOp);
		expectFetchNext("branchesAndJumps");
	endtask

	task automatic runJump(input opcodeT op, input functT fn, input ctrlStateT expState,
		input pcSourceT expSource);
		fetchAndDecode("branchesAndJumps", op, fn);
		idleCycle();
		checkState("branchesAndJumps", expState, stateOut);
		checkBit("branchesAndJumps", "pcWrite", 1'b1, pcWrite);
		checkPcSource("branchesAndJumps", expSource, pcSource);
		expectFetchNext("branchesAndJumps");
	endtask

	task automatic testLuiAddiuNopUnknown();
		fetchAndDecode("luiAddiuNop", lui, fnNop);
		idleCycle();
		checkState("luiAddiuNop", stLui, stateOut);
		checkBit("luiAddiuNop", "regWrite", 1'b1, regWrite);
		checkMemToReg("luiAddiuNop", wbLui, memToReg);
		expectFetchNext("luiAddiuNop");
		fetchAndDecode("luiAddiuNop", addiu, fnNop);
		idleCycle();
		checkState("luiAddiuNop", stAddiu, stateOut);
		checkBit("luiAddiuNop", "aluOutWrite", 1'b1, aluOutWrite);
		checkAluSrcB("luiAddiuNop", srcBImm, aluSrcB);
		checkBit("luiAddiuNop", "aWrite", 1'b0, aWrite);
		checkBit("luiAddiuNop", "bWrite", 1'b0, bWrite);
		idleCycle();
		checkState("luiAddiuNop", stWriteRegAluImm, stateOut);
		checkBit("luiAddiuNop", "regWrite", 1'b1, regWrite);
		checkBit("luiAddiuNop", "regDst", 1'b0, regDst);
		checkMemToReg("luiAddiuNop", wbAlu, memToReg);
		expectFetchNext("luiAddiuNop");
		fetchAndDecode("luiAddiuNop", rType, fnNop);
		idleCycle();
		checkState("luiAddiuNop", stNop, stateOut);
		checkAluOp("luiAddiuNop", aluPass, aluOp);
		expectFetchNext("luiAddiuNop");
		fetchAndDecode("unknown", opcodeT'(6'h3F), fnNop);
		expectFetchNext("unknown"); // no execute state
		fetchAndDecode("unknown", rType, functT'(6'h02)); // srl was dropped
		expectFetchNext("unknown");
	endtask

	task automatic testBreak();
		fetchAndDecode("break", rType, fnBreak);
		repeat (20)
		begin
			idleCycle();
			checkState("break", stBreak, stateOut);
			checkWritesOff("break");
			checkBit("break", "aWrite", 1'b0, aWrite);
			checkBit("break", "bWrite", 1'b0, bWrite);
			checkAluOp("break", aluPass, aluOp);
		end
		applyReset("break");
		fetchAndDecode("break", rType, fnNop);
		idleCycle();
		checkState("break", stNop, stateOut);
		expectFetchNext("break");
	endtask

	initial
	begin
		seed = 93568;
		reset = 1'b1;
		opcode = rType;
		funct = fnNop;
		testResetAndFetch();
		testRTypeAlu();
		testLoadStore();
		runBranch(beq, stBeq, 1'b1);
		runBranch(bne, stBne, 1'b0);
		runJump(j, fnNop, stJ, pcJumpTarget);
		runJump(rType, fnJr, stJr, pcRegister);
		testLuiAddiuNopUnknown();
		testBreak();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule : mipsControlUnitTb

`default_nettype wire

//--- test/mipsControlUnit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControlUnitProperties
(
	input wire logic clk,
	input wire logic reset,
	input mipsControlPkg::ctrlStateT stateOut,
	input wire logic regWrite,
	input wire logic memWrite,
	input wire logic pcWriteCond,
	input wire logic irWrite
);

	import mipsControlPkg::*;

	noDoubleWrite: assert property (@(posedge clk) disable iff (reset)
		!(regWrite && memWrite))
		else $error("regWrite and memWrite high in the same cycle");

	condOnlyInBranch: assert property (@(posedge clk) disable iff (reset)
		pcWriteCond |-> (stateOut == stBeq || stateOut == stBne))
		else $error("pcWriteCond high outside a branch state");

	breakHolds: assert property (@(posedge clk) disable iff (reset)
		(stateOut == stBreak) |=> (stateOut == stBreak))
		else $error("stBreak left without reset");

	irWriteOnlyInIrWrite: assert property (@(posedge clk) disable iff (reset)
		irWrite |-> (stateOut == stIrWrite))
		else $error("irWrite high outside stIrWrite");

endmodule : mipsControlUnitProperties

bind mipsControlUnit mipsControlUnitProperties mipsControlUnitProperties_inst (
	.clk(clk),
	.reset(reset),
	.stateOut(stateOut),
	.regWrite(regWrite),
	.memWrite(memWrite),
	.pcWriteCond(pcWriteCond),
	.irWrite(irWrite)
);

`default_nettype wire
